// ==== verilog/rv_settings.svh ====
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// Datapath width and register count.
`define RV_XLEN   32
`define RV_NREGS  32

// Memory-mapped board I/O registers.
`define RV_REG_LCD   20
`define RV_REG_LEDR  21
`define RV_REG_LEDG  22

// Hex words occupy x23 to x30, one per digit.
`define RV_REG_HEX0  23
`define RV_NDIGITS   8

// Read-only switch register.
`define RV_REG_SW    31

`endif

// ==== verilog/rv_pkg.sv ====
`include "rv_settings.svh"

package rv_pkg;

   localparam int unsigned REG_AW = $clog2(`RV_NREGS);

   // **************************************************
   // Opcode and function fields.
   // **************************************************
   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_LUI    = 7'b0110111;

   localparam logic [2:0] F3_ADD_SUB = 3'b000;
   localparam logic [2:0] F3_SLT     = 3'b010;
   localparam logic [2:0] F3_XOR     = 3'b100;
   localparam logic [2:0] F3_OR      = 3'b110;
   localparam logic [2:0] F3_AND     = 3'b111;

   // Bit 5 selects SUB, every other funct7 bit must be zero.
   localparam logic [6:0] F7_BASE = 7'b0000000;
   localparam logic [6:0] F7_ALT  = 7'b0100000;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_SLT,
      ALU_PASS_B
   } alu_op_e;

   // **************************************************
   // Instruction formats.
   // **************************************************
   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
   } instr_r_t;

   typedef struct packed {
      logic [11:0] imm12;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } instr_i_t;

   typedef struct packed {
      logic [19:0] imm20;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } instr_u_t;

   // One word, read through whichever format the opcode calls for.
   typedef union packed {
      instr_r_t r;
      instr_i_t i;
      instr_u_t u;
   } instr_u;

   typedef struct packed {
      logic [REG_AW-1:0]   rs1;
      logic [REG_AW-1:0]   rs2;
      logic [REG_AW-1:0]   rd;
      logic [`RV_XLEN-1:0] imm;
      logic                use_imm;
      alu_op_e             alu_op;
      logic                reg_we;
   } ctrl_t;

endpackage

// ==== verilog/instr_decoder.sv ====
`include "rv_settings.svh"

module instr_decoder (
   input  logic           valid_i,
   input  rv_pkg::instr_u instr_i,
   output rv_pkg::ctrl_t  ctrl_o,
   output logic           illegal_o
);

   logic legal;
   logic funct7_ok;

   always_comb begin
      ctrl_o        = '0;
      ctrl_o.alu_op = rv_pkg::ALU_ADD;
      legal         = 1'b0;
      // Only bit 5 of funct7 may be set.
      funct7_ok     = (instr_i.r.funct7 & ~rv_pkg::F7_ALT) == rv_pkg::F7_BASE;

      case (instr_i.r.opcode)
         rv_pkg::OPC_OP: begin
            ctrl_o.rs1 = instr_i.r.rs1;
            ctrl_o.rs2 = instr_i.r.rs2;
            ctrl_o.rd  = instr_i.r.rd;
            legal      = funct7_ok;
            case (instr_i.r.funct3)
               rv_pkg::F3_ADD_SUB: begin
                  ctrl_o.alu_op = instr_i.r.funct7[5] ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
               end
               rv_pkg::F3_SLT: ctrl_o.alu_op = rv_pkg::ALU_SLT;
               rv_pkg::F3_XOR: ctrl_o.alu_op = rv_pkg::ALU_XOR;
               rv_pkg::F3_OR:  ctrl_o.alu_op = rv_pkg::ALU_OR;
               rv_pkg::F3_AND: ctrl_o.alu_op = rv_pkg::ALU_AND;
               default:        legal = 1'b0;
            endcase
            // SUB is the only alternate encoding supported.
            if (instr_i.r.funct7[5] && instr_i.r.funct3 != rv_pkg::F3_ADD_SUB) begin
               legal = 1'b0;
            end
         end

         rv_pkg::OPC_OP_IMM: begin
            ctrl_o.rs1     = instr_i.i.rs1;
            ctrl_o.rd      = instr_i.i.rd;
            ctrl_o.imm     = {{(`RV_XLEN-12){instr_i.i.imm12[11]}}, instr_i.i.imm12};
            ctrl_o.use_imm = 1'b1;
            legal          = 1'b1;
            case (instr_i.i.funct3)
               rv_pkg::F3_ADD_SUB: ctrl_o.alu_op = rv_pkg::ALU_ADD;
               rv_pkg::F3_SLT:     ctrl_o.alu_op = rv_pkg::ALU_SLT;
               rv_pkg::F3_XOR:     ctrl_o.alu_op = rv_pkg::ALU_XOR;
               rv_pkg::F3_OR:      ctrl_o.alu_op = rv_pkg::ALU_OR;
               rv_pkg::F3_AND:     ctrl_o.alu_op = rv_pkg::ALU_AND;
               default:            legal = 1'b0;
            endcase
         end

         rv_pkg::OPC_LUI: begin
            ctrl_o.rd      = instr_i.u.rd;
            ctrl_o.imm     = {instr_i.u.imm20, 12'b0};
            ctrl_o.use_imm = 1'b1;
            ctrl_o.alu_op  = rv_pkg::ALU_PASS_B;
            legal          = 1'b1;
         end

         default: legal = 1'b0;
      endcase

      illegal_o     = valid_i && !legal;
      ctrl_o.reg_we = valid_i && legal;
   end

endmodule

// ==== verilog/regfile.sv ====
`include "rv_settings.svh"

module regfile (
   input  logic                                    clk_i,
   input  logic                                    rst_ni,
   input  rv_pkg::ctrl_t                           ctrl_i,
   input  logic [`RV_XLEN-1:0]                     wdata_i,
   input  logic [`RV_XLEN-1:0]                     sw_i,
   output logic [`RV_XLEN-1:0]                     rdata1_o,
   output logic [`RV_XLEN-1:0]                     rdata2_o,
   output logic [`RV_XLEN-1:0]                     lcd_o,
   output logic [`RV_XLEN-1:0]                     ledr_o,
   output logic [`RV_XLEN-1:0]                     ledg_o,
   output logic [`RV_NDIGITS-1:0][`RV_XLEN-1:0]    hex_o
);

   localparam logic [rv_pkg::REG_AW-1:0] SW_IDX = rv_pkg::REG_AW'(`RV_REG_SW);

   // Only x1 to x30 hold state.
   logic [`RV_NREGS-2:1][`RV_XLEN-1:0] regs_q;
   logic                               wr_en;

   function automatic logic [`RV_XLEN-1:0] read_reg(input logic [rv_pkg::REG_AW-1:0] idx);
      if (idx == '0) begin
         return '0;
      end else if (idx == SW_IDX) begin
         return sw_i;
      end
      return regs_q[idx];
   endfunction

   // **************************************************
   // Write port, falling edge.
   // **************************************************
   assign wr_en = ctrl_i.reg_we && (ctrl_i.rd != '0) && (ctrl_i.rd != SW_IDX);

   always_ff @(negedge clk_i) begin
      if (!rst_ni) begin
         regs_q <= '0;
      end else if (wr_en) begin
         regs_q[ctrl_i.rd] <= wdata_i;
      end
   end

   // Operands read zero while in reset.
   always_comb begin
      rdata1_o = '0;
      rdata2_o = '0;
      if (rst_ni) begin
         rdata1_o = read_reg(ctrl_i.rs1);
         rdata2_o = read_reg(ctrl_i.rs2);
      end
   end

   // **************************************************
   // Board I/O.
   // **************************************************
   assign lcd_o  = regs_q[`RV_REG_LCD];
   assign ledr_o = regs_q[`RV_REG_LEDR];
   assign ledg_o = regs_q[`RV_REG_LEDG];

   for (genvar d = 0; d < `RV_NDIGITS; d++) begin : g_hex
      assign hex_o[d] = regs_q[`RV_REG_HEX0 + d];
   end

   // A write aimed at x0 leaves every register as it was.
   a_x0_zero : assert property (@(negedge clk_i) disable iff (!rst_ni)
      (ctrl_i.reg_we && ctrl_i.rd == '0) |=> $stable(regs_q));

   // Writes to the switch register leave all state untouched.
   a_sw_ro : assert property (@(negedge clk_i) disable iff (!rst_ni)
      (ctrl_i.reg_we && ctrl_i.rd == SW_IDX) |=> $stable(regs_q));

endmodule

// ==== verilog/alu.sv ====
`include "rv_settings.svh"

module alu (
   input  rv_pkg::ctrl_t        ctrl_i,
   input  logic [`RV_XLEN-1:0]  op_a_i,
   input  logic [`RV_XLEN-1:0]  op_b_i,
   output logic [`RV_XLEN-1:0]  result_o
);

   logic [`RV_XLEN-1:0] op_b;
   logic                less;

   // Immediate forms replace the second register operand.
   assign op_b = ctrl_i.use_imm ? ctrl_i.imm : op_b_i;

   // Signed compare for SLT and SLTI.
   assign less = $signed(op_a_i) < $signed(op_b);

   // **************************************************
   // Operation select.
   // **************************************************
   always_comb begin
      case (ctrl_i.alu_op)
         rv_pkg::ALU_ADD: begin
            result_o = op_a_i + op_b;
         end
         rv_pkg::ALU_SUB: begin
            result_o = op_a_i - op_b;
         end
         rv_pkg::ALU_AND: begin
            result_o = op_a_i & op_b;
         end
         rv_pkg::ALU_OR: begin
            result_o = op_a_i | op_b;
         end
         rv_pkg::ALU_XOR: begin
            result_o = op_a_i ^ op_b;
         end
         rv_pkg::ALU_SLT: begin
            result_o = {{(`RV_XLEN-1){1'b0}}, less};
         end
         // LUI, immediate already shifted.
         rv_pkg::ALU_PASS_B: begin
            result_o = op_b;
         end
         default: begin
            result_o = '0;
         end
      endcase
   end

endmodule

// ==== verilog/hex_digit_decoder.sv ====
module hex_digit_decoder (
   input  logic [3:0] value_i,
   output logic [6:0] seg_o
);

   // Active low, bit 6 is segment g, bit 0 is segment a.
   always_comb begin
      case (value_i)
         4'h0: seg_o = 7'b1000000;
         4'h1: seg_o = 7'b1111001;
         4'h2: seg_o = 7'b0100100;
         4'h3: seg_o = 7'b0110000;
         4'h4: seg_o = 7'b0011001;
         4'h5: seg_o = 7'b0010010;
         4'h6: seg_o = 7'b0000010;
         4'h7: seg_o = 7'b1111000;
         4'h8: seg_o = 7'b0000000;
         4'h9: seg_o = 7'b0010000;
         4'ha: seg_o = 7'b0001000;
         4'hb: seg_o = 7'b0000011;
         4'hc: seg_o = 7'b1000110;
         4'hd: seg_o = 7'b0100001;
         4'he: seg_o = 7'b0000110;
         4'hf: seg_o = 7'b0001110;
         default: seg_o = 7'b1111111;
      endcase
   end

endmodule

// ==== verilog/rv_io_top.sv ====
`include "rv_settings.svh"

module rv_io_top (
   input  logic                               clk_i,
   input  logic                               rst_ni,
   input  logic                               instr_valid_i,
   input  logic [31:0]                        instr_i,
   input  logic [`RV_XLEN-1:0]                sw_i,
   output logic [`RV_XLEN-1:0]                lcd_o,
   output logic [`RV_XLEN-1:0]                ledr_o,
   output logic [`RV_XLEN-1:0]                ledg_o,
   output logic [`RV_NDIGITS-1:0][6:0]        hex_seg_o,
   output logic                               illegal_o
);

   rv_pkg::ctrl_t                          ctrl;
   logic [`RV_XLEN-1:0]                    rdata1;
   logic [`RV_XLEN-1:0]                    rdata2;
   logic [`RV_XLEN-1:0]                    alu_result;
   logic [`RV_NDIGITS-1:0][`RV_XLEN-1:0]   hex_words;

   // **************************************************
   // Decode, operand read, execute, write back.
   // **************************************************
   instr_decoder u_decoder (
      .valid_i   (instr_valid_i),
      .instr_i   (instr_i),
      .ctrl_o    (ctrl),
      .illegal_o (illegal_o)
   );

   regfile u_regfile (
      .clk_i    (clk_i),
      .rst_ni   (rst_ni),
      .ctrl_i   (ctrl),
      .wdata_i  (alu_result),
      .sw_i     (sw_i),
      .rdata1_o (rdata1),
      .rdata2_o (rdata2),
      .lcd_o    (lcd_o),
      .ledr_o   (ledr_o),
      .ledg_o   (ledg_o),
      .hex_o    (hex_words)
   );

   alu u_alu (
      .ctrl_i   (ctrl),
      .op_a_i   (rdata1),
      .op_b_i   (rdata2),
      .result_o (alu_result)
   );

   // Low nibble of each hex word drives one digit.
   for (genvar d = 0; d < `RV_NDIGITS; d++) begin : g_digit
      hex_digit_decoder u_digit (
         .value_i (hex_words[d][3:0]),
         .seg_o   (hex_seg_o[d])
      );
   end

endmodule

// ==== verification/tb_rv_io.sv ====
`include "rv_settings.svh"

module tb_rv_io;

   localparam int CLK_PERIOD = 40;
   localparam int MAX_CYCLES = 400;

   logic                              clk;
   logic                              rst_n;
   logic                              instr_valid;
   logic [31:0]                       instr_word;
   logic [`RV_XLEN-1:0]               sw;
   logic [`RV_XLEN-1:0]               lcd;
   logic [`RV_XLEN-1:0]               ledr;
   logic [`RV_XLEN-1:0]               ledg;
   logic [`RV_NDIGITS-1:0][6:0]       hex_seg;
   logic                              illegal;

   // Expected contents of every register the DUT may hold.
   logic [`RV_XLEN-1:0] model [0:`RV_NREGS-1];
   int                  errors = 0;
   int                  cycles = 0;
   integer              seed;

   rv_io_top uut (
      .clk_i         (clk),
      .rst_ni        (rst_n),
      .instr_valid_i (instr_valid),
      .instr_i       (instr_word),
      .sw_i          (sw),
      .lcd_o         (lcd),
      .ledr_o        (ledr),
      .ledg_o        (ledg),
      .hex_seg_o     (hex_seg),
      .illegal_o     (illegal)
   );

   initial clk = 1'b0;
   always #(CLK_PERIOD/2) clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
         $display("Verification failed");
         $finish;
      end
   end

   // **************************************************
   // Reference model.
   // **************************************************
   // Active low, segment g down to segment a.
   function automatic logic [6:0] seg_pattern(input logic [3:0] v);
      logic [6:0] table_q [0:15];
      table_q = '{7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000,
                  7'b0011001, 7'b0010010, 7'b0000010, 7'b1111000,
                  7'b0000000, 7'b0010000, 7'b0001000, 7'b0000011,
                  7'b1000110, 7'b0100001, 7'b0000110, 7'b0001110};
      return table_q[v];
   endfunction

   function automatic logic [31:0] read_model(input int idx);
      if (idx == 0) begin
         return '0;
      end else if (idx == `RV_REG_SW) begin
         return sw;
      end
      return model[idx];
   endfunction

   function automatic logic [31:0] expect_alu(input logic [2:0] f3, input logic sub,
                                              input logic [31:0] a, input logic [31:0] b);
      logic [31:0] r;
      case (f3)
         3'b000:  r = sub ? a - b : a + b;
         3'b010:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         3'b100:  r = a ^ b;
         3'b110:  r = a | b;
         3'b111:  r = a & b;
         default: r = '0;
      endcase
      return r;
   endfunction

   task automatic write_model(input int rd, input logic [31:0] value);
      // x0 and the switch register keep their values.
      if (rd != 0 && rd != `RV_REG_SW) begin
         model[rd] = value;
      end
   endtask

   task automatic report_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
      $display("Error at time %0t: %s is %h, expected %h", $time, what, got, expected);
      errors++;
   endtask

   // **************************************************
   // Drivers.
   // **************************************************
   // Strobe one word; result is visible a quarter cycle after the falling edge.
   task automatic issue(input logic [31:0] word, input logic exp_illegal);
      @(posedge clk);
      instr_valid <= 1'b1;
      instr_word  <= word;
      @(negedge clk);
      #(CLK_PERIOD/4);
      if (illegal !== exp_illegal) begin
         report_value("illegal_o", {31'b0, illegal}, {31'b0, exp_illegal});
      end
   endtask

   task automatic idle();
      @(posedge clk);
      instr_valid <= 1'b0;
      instr_word  <= '0;
   endtask

   task automatic do_r(input logic [6:0] f7, input logic [2:0] f3,
                       input int rd, input int rs1, input int rs2);
      rv_pkg::instr_r_t w;
      logic [31:0]      expected;
      w.funct7 = f7;
      w.rs2    = 5'(rs2);
      w.rs1    = 5'(rs1);
      w.funct3 = f3;
      w.rd     = 5'(rd);
      w.opcode = rv_pkg::OPC_OP;
      issue(w, 1'b0);
      expected = expect_alu(f3, f7[5], read_model(rs1), read_model(rs2));
      write_model(rd, expected);
   endtask

   task automatic do_i(input logic [2:0] f3, input int rd, input int rs1,
                       input logic [11:0] imm12);
      rv_pkg::instr_i_t w;
      logic [31:0]      expected;
      w.imm12  = imm12;
      w.rs1    = 5'(rs1);
      w.funct3 = f3;
      w.rd     = 5'(rd);
      w.opcode = rv_pkg::OPC_OP_IMM;
      issue(w, 1'b0);
      expected = expect_alu(f3, 1'b0, read_model(rs1), {{20{imm12[11]}}, imm12});
      write_model(rd, expected);
   endtask

   task automatic do_u(input int rd, input logic [19:0] imm20);
      rv_pkg::instr_u_t w;
      w.imm20  = imm20;
      w.rd     = 5'(rd);
      w.opcode = rv_pkg::OPC_LUI;
      issue(w, 1'b0);
      write_model(rd, {imm20, 12'b0});
   endtask

   task automatic check_io();
      logic [6:0] exp_seg;
      if (lcd !== model[`RV_REG_LCD]) begin
         report_value("lcd_o", lcd, model[`RV_REG_LCD]);
      end
      if (ledr !== model[`RV_REG_LEDR]) begin
         report_value("ledr_o", ledr, model[`RV_REG_LEDR]);
      end
      if (ledg !== model[`RV_REG_LEDG]) begin
         report_value("ledg_o", ledg, model[`RV_REG_LEDG]);
      end
      for (int d = 0; d < `RV_NDIGITS; d++) begin
         exp_seg = seg_pattern(model[`RV_REG_HEX0 + d][3:0]);
         if (hex_seg[d] !== exp_seg) begin
            report_value($sformatf("hex_seg_o[%0d]", d), {25'b0, hex_seg[d]}, {25'b0, exp_seg});
         end
      end
   endtask

   // **************************************************
   // Directed tests.
   // **************************************************
   task automatic test_reset();
      @(negedge clk);
      #(CLK_PERIOD/4);
      check_io();
      if (illegal !== 1'b0) begin
         report_value("illegal_o", {31'b0, illegal}, 32'd0);
      end
   endtask

   task automatic test_imm_ops();
      logic [2:0]  f3s [0:4];
      logic [31:0] r;
      f3s = '{rv_pkg::F3_ADD_SUB, rv_pkg::F3_AND, rv_pkg::F3_OR, rv_pkg::F3_XOR,
              rv_pkg::F3_SLT};
      for (int k = 0; k < 5; k++) begin
         r = $random(seed);
         do_i(f3s[k], `RV_REG_LEDR, 0, r[11:0]);
         check_io();
      end
      r = $random(seed);
      do_u(`RV_REG_LCD, r[31:12]);
      check_io();
      idle();
   endtask

   task automatic test_reg_ops();
      logic [31:0] a;
      logic [31:0] b;
      logic [6:0]  f7s [0:5];
      logic [2:0]  f3s [0:5];
      a = $random(seed);
      b = $random(seed);
      f7s = '{rv_pkg::F7_BASE, rv_pkg::F7_ALT, rv_pkg::F7_BASE, rv_pkg::F7_BASE,
              rv_pkg::F7_BASE, rv_pkg::F7_BASE};
      f3s = '{rv_pkg::F3_ADD_SUB, rv_pkg::F3_ADD_SUB, rv_pkg::F3_AND, rv_pkg::F3_OR,
              rv_pkg::F3_XOR, rv_pkg::F3_SLT};
      do_u(5, a[31:12]);
      do_i(rv_pkg::F3_ADD_SUB, 5, 5, a[11:0]);
      do_u(6, b[31:12]);
      do_i(rv_pkg::F3_ADD_SUB, 6, 6, b[11:0]);
      for (int k = 0; k < 6; k++) begin
         do_r(f7s[k], f3s[k], `RV_REG_LEDG, 5, 6);
         check_io();
      end
      // Swapped operands give the other compare outcome.
      do_r(rv_pkg::F7_BASE, rv_pkg::F3_SLT, `RV_REG_LEDG, 6, 5);
      check_io();
      idle();
   endtask

   task automatic test_switches();
      logic [31:0] r;
      r = $random(seed);
      @(posedge clk);
      sw <= r;
      do_i(rv_pkg::F3_ADD_SUB, `RV_REG_HEX0, `RV_REG_SW, 12'h000);
      check_io();
      r = $random(seed);
      do_i(rv_pkg::F3_ADD_SUB, `RV_REG_SW, 0, r[11:0]);
      do_r(rv_pkg::F7_BASE, rv_pkg::F3_ADD_SUB, `RV_REG_LEDR, `RV_REG_SW, 0);
      check_io();
      if (ledr !== sw) begin
         report_value("ledr_o after write to x31", ledr, sw);
      end
      idle();
   endtask

   task automatic test_x0_illegal();
      rv_pkg::instr_r_t w;
      do_i(rv_pkg::F3_ADD_SUB, 0, 0, 12'h5a5);
      do_r(rv_pkg::F7_BASE, rv_pkg::F3_OR, 0, `RV_REG_SW, `RV_REG_SW);
      do_i(rv_pkg::F3_ADD_SUB, `RV_REG_LEDR, 0, 12'h000);
      check_io();
      do_i(rv_pkg::F3_ADD_SUB, `RV_REG_LEDR, 0, 12'h123);
      check_io();
      // Branch opcode, not supported.
      w.funct7 = rv_pkg::F7_BASE;
      w.rs2    = 5'd0;
      w.rs1    = 5'(`RV_REG_SW);
      w.funct3 = rv_pkg::F3_ADD_SUB;
      w.rd     = 5'(`RV_REG_LEDR);
      w.opcode = 7'b1100011;
      issue(w, 1'b1);
      check_io();
      // Multiply encoding, also rejected.
      w.funct7 = 7'b0000001;
      w.opcode = rv_pkg::OPC_OP;
      issue(w, 1'b1);
      check_io();
      idle();
      @(negedge clk);
      #(CLK_PERIOD/4);
      if (illegal !== 1'b0) begin
         report_value("illegal_o after strobe", {31'b0, illegal}, 32'd0);
      end
   endtask

   task automatic test_hex_digits();
      for (int v = 0; v < 16; v++) begin
         do_i(rv_pkg::F3_ADD_SUB, `RV_REG_HEX0 + (v % 8), 0, 12'(v));
         if (v % 8 == 7) begin
            check_io();
         end
      end
      idle();
   endtask

   initial begin
      seed        = 32'hc1b45c66;
      rst_n       = 1'b0;
      instr_valid = 1'b0;
      instr_word  = '0;
      sw          = '0;
      for (int k = 0; k < `RV_NREGS; k++) begin
         model[k] = '0;
      end
      repeat (2) @(posedge clk);
      rst_n <= 1'b1;

      test_reset();
      test_imm_ops();
      test_reg_ops();
      test_switches();
      test_x0_illegal();
      test_hex_digits();

      $display("Finished after %0d cycles with %0d errors", cycles, errors);
      if (errors == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

// ==== tb.f ====
+incdir+verilog
verilog/rv_pkg.sv
verilog/instr_decoder.sv
verilog/regfile.sv
verilog/alu.sv
verilog/hex_digit_decoder.sv
verilog/rv_io_top.sv
verification/tb_rv_io.sv

// ==== Makefile ====
# Verilator build and run for the RV32I I/O slice.

VERILATOR ?= verilator
TOP       ?= tb_rv_io
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Verification passed

SOURCES := $(wildcard verilog/*.sv verilog/*.svh verification/*.sv)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
